// ==== logic/exec_unit.sv ====
/*
 * Execution unit
 * Accepts one instruction, executes it in the following cycle,
 * writes back, updates the display and the sticky error flags
 */
`default_nettype none

module exec_unit (
    input  logic             clk,
    input  logic             reset,
    input  logic             instr_valid,
    output logic             instr_ready,
    input  team_pkg::instr_t instr,
    regfile_if.exec          rf,
    output logic [7:0]       display,
    output logic             opcode_error,  // Sticky, undefined opcode seen
    output logic             alu_error      // Sticky, signed overflow seen
);

    logic             busy;     // Execute cycle
    team_pkg::instr_t cur;      // Accepted instruction
    logic             use_rd;   // rd is also the source
    logic [7:0]       a, b;
    logic [9:0]       a_ext, b_ext, wide;
    logic [7:0]       result;
    logic             wr_en, arith, show, bad_op, ovf;

    assign instr_ready = !busy;

    always_ff @(posedge clk) begin
        if (reset) busy <= 1'b0;
        else       busy <= instr_valid && !busy;  // Accept, then one execute cycle
    end

    always_ff @(posedge clk) begin
        if (instr_valid && !busy) cur <= instr;
    end

    // Operand fetch
    assign use_rd = (cur.r.opcode == team_pkg::ADDI) || (cur.r.opcode == team_pkg::SHOW);
    assign rf.rs1 = use_rd ? cur.r.rd : cur.r.rs1;
    assign rf.rs2 = cur.r.rs2;
    assign a      = rf.rdata1;
    assign b      = rf.rdata2;
    assign a_ext  = {{2{a[7]}}, a};  // Sign extend for overflow check
    assign b_ext  = {{2{b[7]}}, b};

    always_comb begin
        wide   = '0;
        result = '0;
        wr_en  = 1'b0;
        arith  = 1'b0;
        show   = 1'b0;
        bad_op = 1'b0;
        case (cur.r.opcode)
            team_pkg::ADD: begin
                wide  = a_ext + b_ext;
                arith = 1'b1;
            end
            team_pkg::SUB: begin
                wide  = a_ext - b_ext;
                arith = 1'b1;
            end
            team_pkg::AND:  result = a & b;
            team_pkg::OR:   result = a | b;
            team_pkg::XOR:  result = a ^ b;
            team_pkg::LDI:  result = cur.i.imm;
            team_pkg::ADDI: begin
                wide  = a_ext + {2'b00, cur.i.imm};  // Immediate is unsigned
                arith = 1'b1;
            end
            team_pkg::SHOW: show = 1'b1;
            default:        bad_op = 1'b1;  // Codes 8 to 15
        endcase
        if (arith) result = wide[7:0];  // Wrapped result still written
        wr_en = !show && !bad_op;
    end

    // True result outside -128..127
    assign ovf = arith && (wide[9:7] != 3'b000) && (wide[9:7] != 3'b111);

    assign rf.we    = busy && wr_en;
    assign rf.waddr = cur.r.rd;
    assign rf.wdata = result;

    always_ff @(posedge clk) begin
        if (reset) begin
            display      <= '0;
            opcode_error <= 1'b0;
            alu_error    <= 1'b0;
        end else if (busy) begin
            if (show)   display      <= a;  // rd read through port 1
            if (bad_op) opcode_error <= 1'b1;
            if (ovf)    alu_error    <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/instr_assembler.sv ====
/*
 * Instruction assembler
 * Pairs received bytes, high byte first, into one 16-bit instruction
 * and holds it with valid until the execution unit takes it
 */
`default_nettype none

module instr_assembler (
    input  logic             clk,
    input  logic             reset,
    input  logic             byte_valid,
    input  logic [7:0]       byte_data,
    output logic             instr_valid,
    input  logic             instr_ready,
    output team_pkg::instr_t instr
);

    logic       half_full;  // High byte captured, waiting for low
    logic [7:0] hi_byte;
    logic       take_byte;

    // Nothing is taken while an instruction is pending
    assign take_byte = byte_valid && !instr_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            half_full   <= 1'b0;
            instr_valid <= 1'b0;
        end else if (instr_valid) begin
            if (instr_ready) instr_valid <= 1'b0;  // Transfer done
        end else if (byte_valid) begin
            if (half_full) begin
                instr_valid <= 1'b1;  // Low byte completes the word
                half_full   <= 1'b0;
            end else begin
                half_full <= 1'b1;
            end
        end
    end

    // Payload, no reset needed
    always_ff @(posedge clk) begin
        if (take_byte) begin
            if (half_full) begin
                instr <= {hi_byte, byte_data};
            end else begin
                hi_byte <= byte_data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
/*
 * Register file
 * Eight 8-bit registers, two combinational reads, one clocked write
 */
`default_nettype none

module reg_file (
    input logic clk,
    input logic reset,
    regfile_if.regs regs
);

    logic [7:0] mem [8];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                mem[i] <= '0;  // Calculator starts from all zero
            end
        end else if (regs.we) begin
            mem[regs.waddr] <= regs.wdata;
        end
    end

    // Reads see the old value during a write cycle
    assign regs.rdata1 = mem[regs.rs1];
    assign regs.rdata2 = mem[regs.rs2];

endmodule

`default_nettype wire

// ==== logic/regfile_if.sv ====
/*
 * Register file port bundle
 * Two combinational read ports and one clocked write port
 */
`default_nettype none

interface regfile_if;

    team_pkg::reg_addr_t rs1;     // Read port 1 address
    team_pkg::reg_addr_t rs2;     // Read port 2 address
    logic [7:0]          rdata1;
    logic [7:0]          rdata2;
    logic                we;      // Write on the next edge
    team_pkg::reg_addr_t waddr;
    logic [7:0]          wdata;

    // Execution side drives addresses and write data
    modport exec (
        output rs1, rs2, we, waddr, wdata,
        input  rdata1, rdata2
    );

    // Storage side answers with read data
    modport regs (
        input  rs1, rs2, we, waddr, wdata,
        output rdata1, rdata2
    );

endinterface

`default_nettype wire

// ==== logic/team_params.svh ====
/*
 * Calculator chip constants
 * UART bit timing, 640x480 VGA timing and breakout pin numbers
 */
`ifndef TEAM_PARAMS_SVH
`define TEAM_PARAMS_SVH

// 25 MHz core clock, 115200 baud
`define CLKS_PER_BIT 217

// Horizontal timing in pixel clocks, 800 per line
`define H_VISIBLE 640
`define H_FRONT   16
`define H_SYNC    96
`define H_BACK    48

// Vertical timing in lines, 525 per frame
`define V_VISIBLE 480
`define V_FRONT   10
`define V_SYNC    2
`define V_BACK    33

`define BAR_WIDTH 80  // Pixels per display bit

// Breakout pin numbers
`define RX_PIN   5
`define DISP_LSB 8

`endif

// ==== logic/team_pkg.sv ====
/*
 * Calculator chip types
 * Opcode encoding and the two decodings of the 16-bit instruction word
 */
`default_nettype none

package team_pkg;

    typedef logic [2:0] reg_addr_t;  // One of eight registers

    // Codes 8 to 15 are undefined
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        LDI  = 4'd5,
        ADDI = 4'd6,
        SHOW = 4'd7
    } opcode_e;

    // Register form, rd = rs1 op rs2
    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic [2:0] unused;
    } instr_reg_t;

    // Immediate form, 8-bit constant in the low byte
    typedef struct packed {
        opcode_e    opcode;
        reg_addr_t  rd;
        logic       unused;
        logic [7:0] imm;
    } instr_imm_t;

    // Same 16 bits, field view picked by opcode
    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_t;

endpackage

`default_nettype wire

// ==== logic/team_top.sv ====
/*
 * Calculator chip top
 * UART instruction input, execution unit with register file,
 * VGA bars and display on the breakout pins, video gated by en
 */
`default_nettype none
`include "team_params.svh"

module team_top (
    input  logic        clk,
    input  logic        reset,
    input  logic        en,        // Low forces video pins to zero
    input  logic [33:0] gpio_in,
    output logic [33:0] gpio_out,
    output logic [33:0] gpio_oeb   // Active-low output enable
);

    logic             byte_valid;
    logic [7:0]       byte_data;
    logic             instr_valid, instr_ready;
    team_pkg::instr_t instr;
    logic [7:0]       display;
    logic             opcode_error, alu_error;
    logic             h_sync, v_sync, pixel;

    regfile_if rf_bus ();

    uart_rx uart_rx_inst (
        .clk        (clk),
        .reset      (reset),
        .rx         (gpio_in[`RX_PIN]),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    instr_assembler instr_assembler_inst (
        .clk         (clk),
        .reset       (reset),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr)
    );

    exec_unit exec_unit_inst (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .instr        (instr),
        .rf           (rf_bus.exec),
        .display      (display),
        .opcode_error (opcode_error),
        .alu_error    (alu_error)
    );

    reg_file reg_file_inst (
        .clk   (clk),
        .reset (reset),
        .regs  (rf_bus.regs)
    );

    vga_timing vga_timing_inst (
        .clk     (clk),
        .reset   (reset),
        .display (display),
        .h_sync  (h_sync),
        .v_sync  (v_sync),
        .pixel   (pixel)
    );

    // Pin map, unused outputs low
    always_comb begin
        gpio_out                   = '0;
        gpio_out[0]                = en & h_sync;  // Video off when disabled
        gpio_out[1]                = en & v_sync;
        gpio_out[2]                = en & pixel;
        gpio_out[3]                = opcode_error;
        gpio_out[4]                = alu_error;
        gpio_out[`DISP_LSB +: 8]   = display;
    end

    always_comb begin
        gpio_oeb                 = '1;  // Inputs by default
        gpio_oeb[4:0]            = '0;  // Video and error pins
        gpio_oeb[`DISP_LSB +: 8] = '0;
    end

endmodule

`default_nettype wire

// ==== logic/uart_rx.sv ====
/*
 * UART receiver, 8N1, LSB first
 * Start edge confirmed at mid-bit, data and stop sampled at mid-bit
 * One-cycle strobe per correctly framed byte
 */
`default_nettype none
`include "team_params.svh"

module uart_rx (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,          // Async serial line, idles high
    output logic       byte_valid,  // One-cycle strobe
    output logic [7:0] byte_data
);

    localparam int CNT_W = $clog2(`CLKS_PER_BIT);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_e;

    state_e           state;
    logic             rx_meta, rx_sync;  // Two-flop synchronizer
    logic [CNT_W-1:0] bit_cnt;           // Cycles within current bit
    logic [2:0]       bit_idx;           // Data bit number
    logic [7:0]       shift;
    logic             half_bit, full_bit;

    assign half_bit = (bit_cnt == CNT_W'(`CLKS_PER_BIT / 2 - 1));
    assign full_bit = (bit_cnt == CNT_W'(`CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta    <= 1'b1;  // Line idle
            rx_sync    <= 1'b1;
            state      <= IDLE;
            bit_cnt    <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            rx_meta    <= rx;
            rx_sync    <= rx_meta;
            byte_valid <= 1'b0;
            case (state)
                IDLE: begin
                    bit_cnt <= '0;
                    if (!rx_sync) state <= START;  // Falling edge seen
                end
                START: begin
                    if (half_bit) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? IDLE : DATA;  // Glitch goes back to idle
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                DATA: begin
                    if (full_bit) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= STOP;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                STOP: begin
                    if (full_bit) begin
                        bit_cnt    <= '0;
                        byte_valid <= rx_sync;  // Low stop bit drops the byte
                        state      <= IDLE;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Data bits enter at the top, LSB ends up at bit 0
    always_ff @(posedge clk) begin
        if (state == DATA && full_bit) shift <= {rx_sync, shift[7:1]};
    end

    assign byte_data = shift;

endmodule

`default_nettype wire

// ==== logic/vga_timing.sv ====
/*
 * VGA timing generator, 640x480
 * Active-low syncs, display register drawn as eight vertical bars,
 * MSB on the left
 */
`default_nettype none
`include "team_params.svh"

module vga_timing (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] display,
    output logic       h_sync,
    output logic       v_sync,
    output logic       pixel
);

    localparam int H_TOTAL  = `H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK;  // 800
    localparam int V_TOTAL  = `V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK;  // 525
    localparam int H_SYNC_0 = `H_VISIBLE + `H_FRONT;
    localparam int V_SYNC_0 = `V_VISIBLE + `V_FRONT;

    logic [9:0] h_cnt, v_cnt;
    logic [6:0] bar_px;   // Pixel within current bar
    logic [2:0] bar_idx;  // Bar number, column / BAR_WIDTH
    logic       line_end, visible;

    assign line_end = (h_cnt == 10'(H_TOTAL - 1));
    assign visible  = (h_cnt < 10'(`H_VISIBLE)) && (v_cnt < 10'(`V_VISIBLE));

    always_ff @(posedge clk) begin
        if (reset) begin
            h_cnt   <= '0;
            v_cnt   <= '0;
            bar_px  <= '0;
            bar_idx <= '0;
        end else begin
            if (line_end) begin
                h_cnt   <= '0;
                bar_px  <= '0;
                bar_idx <= '0;
                v_cnt   <= (v_cnt == 10'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
                if (bar_px == 7'(`BAR_WIDTH - 1)) begin
                    bar_px  <= '0;
                    bar_idx <= bar_idx + 1'b1;  // Wraps in blanking, harmless
                end else begin
                    bar_px <= bar_px + 1'b1;
                end
            end
        end
    end

    // Outputs one cycle behind the counters
    always_ff @(posedge clk) begin
        if (reset) begin
            h_sync <= 1'b1;  // Inactive
            v_sync <= 1'b1;
            pixel  <= 1'b0;
        end else begin
            h_sync <= !((h_cnt >= 10'(H_SYNC_0)) && (h_cnt < 10'(H_SYNC_0 + `H_SYNC)));
            v_sync <= !((v_cnt >= 10'(V_SYNC_0)) && (v_cnt < 10'(V_SYNC_0 + `V_SYNC)));
            pixel  <= visible && display[3'd7 - bar_idx];
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+logic
logic/team_pkg.sv
logic/regfile_if.sv
logic/uart_rx.sv
logic/instr_assembler.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/vga_timing.sv
logic/team_top.sv
sim/tb_team_top.sv

// ==== sim/tb_team_top.sv ====
/*
 * Testbench for the calculator chip
 * Random instruction stream over the UART pin against a register model,
 * then VGA timing, bar pattern and enable gating
 */
`default_nettype none
`include "team_params.svh"

module tb_team_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_RANDOM  = 150;
    localparam int NUM_INSTR = 16 + 2 * N_RANDOM + 5 + 8 + 16 + 2;  // Every instruction sent
    localparam int BYTE_CYC  = 10 * `CLKS_PER_BIT;
    localparam int H_TOTAL   = `H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int V_TOTAL   = `V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK;
    // Two bytes plus a byte of settling per instruction, three frames of video
    localparam longint WATCHDOG_NS =
        (longint'(NUM_INSTR) * 30 * `CLKS_PER_BIT + 3 * H_TOTAL * V_TOTAL + 1000) * 40;

    logic        clk;
    logic        reset;
    logic        en;
    logic [33:0] gpio_in;
    logic [33:0] gpio_out;
    logic [33:0] gpio_oeb;

    logic [15:0] lfsr = 16'd54;
    logic [7:0]  model_regs [8];  // Expected register contents
    logic [7:0]  model_disp;
    logic        model_alu, model_op;  // Sticky flags

    team_top team_top_inst (
        .clk      (clk),
        .reset    (reset),
        .en       (en),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oeb (gpio_oeb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 25 MHz
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout, the run went past its time limit");
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v    = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (expected == actual) else begin
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic [15:0] reg_word(input logic [3:0] op, input logic [2:0] rd,
                                             input logic [2:0] rs1, input logic [2:0] rs2);
        return {op, rd, rs1, rs2, 3'b000};
    endfunction

    function automatic logic [15:0] imm_word(input logic [3:0] op, input logic [2:0] rd,
                                             input logic [7:0] imm);
        return {op, rd, 1'b0, imm};
    endfunction

    // Pins the chip drives, video and flags low, display byte above
    function automatic logic [33:0] driven_mask();
        logic [33:0] m;
        m = '0;
        for (int i = 0; i < 5; i++) m[i] = 1'b1;
        for (int i = 0; i < 8; i++) m[`DISP_LSB + i] = 1'b1;
        return m;
    endfunction

    // Output enables and idle pins
    task automatic pin_check(input string name);
        logic [33:0] idle;
        idle = ~driven_mask();
        check_value({name, "_oeb"}, idle, gpio_oeb);
        check_value({name, "_unused_out"}, 0, gpio_out & idle);
    endtask

    // 8N1, LSB first, called and returning on a falling edge
    task automatic send_byte(input logic [7:0] b);
        gpio_in[`RX_PIN] = 1'b0;  // Start bit
        repeat (`CLKS_PER_BIT) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            gpio_in[`RX_PIN] = b[i];
            repeat (`CLKS_PER_BIT) @(negedge clk);
        end
        gpio_in[`RX_PIN] = 1'b1;  // Stop bit, line idles high after
        repeat (`CLKS_PER_BIT) @(negedge clk);
    endtask

    // Reference behaviour of one instruction
    task automatic apply_model(input logic [15:0] w);
        logic [3:0] op;
        logic [2:0] rd, rs1, rs2;
        logic [7:0] imm;
        int         sa, sb, res;
        op  = w[15:12];
        rd  = w[11:9];
        rs1 = w[8:6];
        rs2 = w[5:3];
        imm = w[7:0];
        sa  = $signed(model_regs[rs1]);
        sb  = $signed(model_regs[rs2]);
        case (op)
            team_pkg::ADD:  res = sa + sb;
            team_pkg::SUB:  res = sa - sb;
            team_pkg::AND:  res = model_regs[rs1] & model_regs[rs2];
            team_pkg::OR:   res = model_regs[rs1] | model_regs[rs2];
            team_pkg::XOR:  res = model_regs[rs1] ^ model_regs[rs2];
            team_pkg::LDI:  res = imm;
            team_pkg::ADDI: res = int'($signed(model_regs[rd])) + int'(imm);  // Unsigned imm
            default:        res = 0;
        endcase
        if (op == team_pkg::ADD || op == team_pkg::SUB || op == team_pkg::ADDI) begin
            if (res > 127 || res < -128) model_alu = 1'b1;  // Signed overflow
        end
        if (op == team_pkg::SHOW) model_disp = model_regs[rd];
        else if (op > 4'd7)       model_op   = 1'b1;
        else                      model_regs[rd] = res[7:0];  // Wrapped
    endtask

    task automatic run_instr(input logic [15:0] w);
        send_byte(w[15:8]);  // High byte first
        send_byte(w[7:0]);
        apply_model(w);
    endtask

    // SHOW a register, give it a byte time, compare all status pins
    task automatic show_check(input string name, input logic [2:0] rd);
        run_instr(reg_word(team_pkg::SHOW, rd, 3'd0, 3'd0));
        repeat (BYTE_CYC) @(negedge clk);
        check_value({name, "_display"}, model_disp, gpio_out[`DISP_LSB +: 8]);
        check_value({name, "_alu_flag"}, model_alu, gpio_out[4]);
        check_value({name, "_op_flag"}, model_op, gpio_out[3]);
    endtask

    task automatic reset_dut();
        reset = 1'b1;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < 8; i++) model_regs[i] = '0;
        model_disp = '0;
        model_alu  = 1'b0;
        model_op   = 1'b0;
    endtask

    // Cycles between two falling edges of a pin, sampled on falling clock edges
    task automatic fall_period(input int pin, output int period);
        logic prev;
        do begin
            prev = gpio_out[pin];
            @(negedge clk);
        end while (!(prev && !gpio_out[pin]));
        period = 0;
        do begin
            prev = gpio_out[pin];
            @(negedge clk);
            period++;
        end while (!(prev && !gpio_out[pin]));
    endtask

    task automatic wait_rise(input int pin);
        logic prev;
        do begin
            prev = gpio_out[pin];
            @(negedge clk);
        end while (!(!prev && gpio_out[pin]));
    endtask

    initial begin : main
        logic [15:0] v, op, rd, rs1, rs2, imm;
        logic [15:0] w;
        int          p;
        reset   = 1'b1;
        en      = 1'b1;
        gpio_in = '0;
        gpio_in[`RX_PIN] = 1'b1;  // Idle line
        reset_dut();
        pin_check("reset_pins");

        // Load and show every register
        for (int r = 0; r < 8; r++) begin
            imm = rand_bits(8);
            run_instr(imm_word(team_pkg::LDI, 3'(r), imm[7:0]));
        end
        for (int r = 0; r < 8; r++) show_check("load_show", 3'(r));

        // Random defined instructions, each made visible through SHOW
        for (int n = 0; n < N_RANDOM; n++) begin
            op  = rand_bits(3);
            rd  = rand_bits(3);
            rs1 = rand_bits(3);
            rs2 = rand_bits(3);
            imm = rand_bits(8);
            if (op[3:0] == team_pkg::LDI || op[3:0] == team_pkg::ADDI)
                w = imm_word(op[3:0], rd[2:0], imm[7:0]);
            else
                w = reg_word(op[3:0], rd[2:0], rs1[2:0], rs2[2:0]);
            run_instr(w);
            show_check("alu_stream", rd[2:0]);
        end

        // Forced overflow from a clean state, 127 + 1
        reset_dut();
        run_instr(imm_word(team_pkg::LDI, 3'd1, 8'd127));
        run_instr(imm_word(team_pkg::LDI, 3'd2, 8'd1));
        show_check("overflow_before", 3'd1);
        run_instr(reg_word(team_pkg::ADD, 3'd3, 3'd1, 3'd2));
        show_check("overflow", 3'd3);

        // Undefined opcodes leave registers alone and latch the flag
        reset_dut();
        for (int r = 0; r < 8; r++) begin
            imm = rand_bits(8);
            run_instr(imm_word(team_pkg::LDI, 3'(r), imm[7:0] | 8'h01));  // Nonzero, stray write shows
        end
        for (int code = 8; code < 16; code++) begin
            v = rand_bits(12);
            run_instr({4'(code), v[11:0]});
            repeat (BYTE_CYC) @(negedge clk);
            check_value("undefined_op_flag", 1, gpio_out[3]);
            show_check("undefined_op", v[11:9]);
        end

        // Known pattern for the bars
        imm = rand_bits(8);
        run_instr(imm_word(team_pkg::LDI, 3'd7, imm[7:0] ^ 8'hA5));
        show_check("bars_setup", 3'd7);
        pin_check("running_pins");

        fall_period(0, p);
        check_value("h_sync_period", H_TOTAL, p);
        fall_period(1, p);
        check_value("v_sync_period", H_TOTAL * V_TOTAL, p);

        // From end of v_sync, 40 line ends reach a visible line
        wait_rise(1);
        repeat (40) wait_rise(0);
        repeat (`H_BACK) @(negedge clk);  // Now at column 0
        for (int c = 0; c < `H_VISIBLE; c++) begin
            check_value("bars", model_disp[7 - c / `BAR_WIDTH], gpio_out[2]);
            @(negedge clk);
        end

        // Enable low for one line
        en = 1'b0;
        for (int i = 0; i < H_TOTAL; i++) begin
            @(negedge clk);
            check_value("enable_video", 0, gpio_out[2:0]);
            check_value("enable_display", model_disp, gpio_out[`DISP_LSB +: 8]);
        end
        en = 1'b1;
        fall_period(0, p);  // Syncs back
        check_value("enable_resume", H_TOTAL, p);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
